// ==== hw/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath width
`define CPU_XLEN 32

// register index width, 32 registers
`define CPU_REG_W 5

// data memory size in words
`define CPU_DMEM_DEPTH 256

// word address taken from byte address bits 9..2
`define CPU_DMEM_AW 8

`endif

// ==== hw/cpu_pkg.sv ====
`include "cpu_defs.svh"

package cpu_pkg;

   typedef logic [`CPU_XLEN-1:0]  word_t;
   typedef logic [`CPU_REG_W-1:0] reg_idx_t;

   // primary opcode, bits 31..26
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_ADDI  = 6'h08,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2B
   } opcode_e;

   typedef enum logic [5:0] {
      F_ADD = 6'h20,
      F_SUB = 6'h22,
      F_AND = 6'h24,
      F_OR  = 6'h25,
      F_XOR = 6'h26
   } funct_e;

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

   typedef struct packed {
      opcode_e    opcode;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [4:0] shamt;   // unused, no shifts here
      funct_e     funct;
   } r_fmt_t;

   typedef struct packed {
      opcode_e     opcode;
      reg_idx_t    rs;
      reg_idx_t    rt;
      logic [15:0] imm;    // sign-extended in decode
   } i_fmt_t;

   // one instruction word, two views
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

   typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

endpackage

// ==== hw/cpu_top.sv ====
module cpu_top
   import cpu_pkg::*;
(
   input  logic     CLK_pi,
   input  logic     CPU_RESET_pi,
   input  word_t    instr,
   input  logic     instr_valid,
   output logic     wb_valid,
   output reg_idx_t wb_dest,
   output word_t    wb_data
);

   reg_idx_t rs_idx;
   reg_idx_t rt_idx;
   word_t    rs_data;
   word_t    rt_data;

   id_ex_if  u_id_ex ();   // ID/EX
   ex_mem_if u_ex_mem ();  // EX/MEM

   decode_stage i_decode (
      .CLK_pi       (CLK_pi),
      .CPU_RESET_pi (CPU_RESET_pi),
      .instr        (instr),
      .instr_valid  (instr_valid),
      .rs_idx       (rs_idx),
      .rt_idx       (rt_idx),
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .id_ex        (u_id_ex.decode)
   );

   reg_file i_reg_file (
      .CLK_pi       (CLK_pi),
      .CPU_RESET_pi (CPU_RESET_pi),
      .rs_idx       (rs_idx),
      .rt_idx       (rt_idx),
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .wb_valid     (wb_valid),
      .wb_dest      (wb_dest),
      .wb_data      (wb_data)
   );

   execute_stage i_execute (
      .CLK_pi       (CLK_pi),
      .CPU_RESET_pi (CPU_RESET_pi),
      .id_ex        (u_id_ex.execute),
      .wb_valid     (wb_valid),    // WB forwarding source
      .wb_dest      (wb_dest),
      .wb_data      (wb_data),
      .ex_mem       (u_ex_mem.execute)
   );

   mem_wb_stage i_mem_wb (
      .CLK_pi       (CLK_pi),
      .CPU_RESET_pi (CPU_RESET_pi),
      .ex_mem       (u_ex_mem.memory),
      .wb_valid     (wb_valid),
      .wb_dest      (wb_dest),
      .wb_data      (wb_data)
   );

endmodule

// ==== hw/decode_stage.sv ====
`include "cpu_defs.svh"

module decode_stage
   import cpu_pkg::*;
(
   input  logic     CLK_pi,
   input  logic     CPU_RESET_pi,
   input  word_t    instr,
   input  logic     instr_valid,
   output reg_idx_t rs_idx,
   output reg_idx_t rt_idx,
   input  word_t    rs_data,
   input  word_t    rt_data,
   id_ex_if.decode  id_ex
);

   word_t    if_id_instr;  // IF/ID word
   logic     if_id_valid;  // IF/ID strobe
   instr_u   ir;
   logic     known;        // opcode and funct recognized
   logic     go;           // real instruction, goes on to EX
   logic     writes;
   logic     use_imm;
   logic     load;
   logic     store;
   alu_op_e  alu_op;
   reg_idx_t dest;
   word_t    imm;

   always_ff @(posedge CLK_pi) begin
      if (CPU_RESET_pi) if_id_valid <= 1'b0;
      else              if_id_valid <= instr_valid;  // low strobe -> bubble
   end

   always_ff @(posedge CLK_pi) if_id_instr <= instr;

   assign ir     = if_id_instr;
   assign rs_idx = ir.r.rs;   // same bits in both views
   assign rt_idx = ir.r.rt;
   assign imm    = {{(`CPU_XLEN-16){ir.i.imm[15]}}, ir.i.imm};
   assign go     = if_id_valid && known;

   always_comb begin
      known   = 1'b1;
      writes  = 1'b1;
      use_imm = 1'b1;  // I-format defaults
      load    = 1'b0;
      store   = 1'b0;
      alu_op  = ALU_ADD;
      dest    = ir.i.rt;
      case (ir.r.opcode)
         OP_RTYPE: begin
            use_imm = 1'b0;
            dest    = ir.r.rd;  // R view
            case (ir.r.funct)
               F_ADD:   alu_op = ALU_ADD;
               F_SUB:   alu_op = ALU_SUB;
               F_AND:   alu_op = ALU_AND;
               F_OR:    alu_op = ALU_OR;
               F_XOR:   alu_op = ALU_XOR;
               default: known  = 1'b0;
            endcase
         end
         OP_ADDI: alu_op = ALU_ADD;
         OP_LW:   load   = 1'b1;    // address = rs + imm
         OP_SW: begin
            store  = 1'b1;
            writes = 1'b0;
         end
         default: known = 1'b0;
      endcase
   end

   always_ff @(posedge CLK_pi) begin
      if (CPU_RESET_pi) begin
         id_ex.valid   <= 1'b0;
         id_ex.we      <= 1'b0;
         id_ex.load    <= 1'b0;
         id_ex.store   <= 1'b0;
         id_ex.use_imm <= 1'b0;
      end else begin
         id_ex.valid   <= go;
         id_ex.we      <= go && writes && (dest != '0);  // r0 writes dropped here
         id_ex.load    <= go && load;
         id_ex.store   <= go && store;
         id_ex.use_imm <= go && use_imm;
      end
   end

   always_ff @(posedge CLK_pi) begin
      id_ex.alu_op <= alu_op;
      id_ex.imm    <= imm;
      id_ex.op1    <= rs_data;  // from reg file, bypass included
      id_ex.op2    <= rt_data;
      id_ex.rs     <= rs_idx;
      id_ex.rt     <= rt_idx;
      id_ex.dest   <= dest;
   end

endmodule

// ==== hw/execute_stage.sv ====
module execute_stage
   import cpu_pkg::*;
(
   input  logic      CLK_pi,
   input  logic      CPU_RESET_pi,
   id_ex_if.execute  id_ex,
   input  logic      wb_valid,
   input  reg_idx_t  wb_dest,
   input  word_t     wb_data,
   ex_mem_if.execute ex_mem
);

   fwd_sel_e fwd_a;
   fwd_sel_e fwd_b;
   word_t    opa;      // rs after forwarding
   word_t    opb;      // rt after forwarding, doubles as store data
   word_t    alu_b;
   word_t    result;

   // MEM stage is younger, so it beats WB
   function automatic fwd_sel_e pick_src(input reg_idx_t src, input logic mem_we,
                                         input reg_idx_t mem_dest, input logic wb_we,
                                         input reg_idx_t wb_d);
      if (mem_we && mem_dest == src) return FWD_MEM;
      if (wb_we && wb_d == src)      return FWD_WB;
      return FWD_NONE;
   endfunction

   function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                     input word_t mem_val, input word_t wb_val);
      case (sel)
         FWD_MEM: return mem_val;
         FWD_WB:  return wb_val;
         default: return reg_val;
      endcase
   endfunction

   // we is never set for r0 upstream, so r0 can't match
   assign fwd_a = pick_src(id_ex.rs, ex_mem.we, ex_mem.dest, wb_valid, wb_dest);
   assign fwd_b = pick_src(id_ex.rt, ex_mem.we, ex_mem.dest, wb_valid, wb_dest);

   assign opa   = fwd_mux(fwd_a, id_ex.op1, ex_mem.result, wb_data);
   assign opb   = fwd_mux(fwd_b, id_ex.op2, ex_mem.result, wb_data);
   assign alu_b = id_ex.use_imm ? id_ex.imm : opb;  // ADDI, LW, SW

   always_comb begin
      case (id_ex.alu_op)
         ALU_SUB: result = opa - alu_b;
         ALU_AND: result = opa & alu_b;
         ALU_OR:  result = opa | alu_b;
         ALU_XOR: result = opa ^ alu_b;
         default: result = opa + alu_b;   // add, also address calc
      endcase
   end

   always_ff @(posedge CLK_pi) begin
      if (CPU_RESET_pi) begin
         ex_mem.valid <= 1'b0;
         ex_mem.we    <= 1'b0;
         ex_mem.load  <= 1'b0;
         ex_mem.store <= 1'b0;
      end else begin
         ex_mem.valid <= id_ex.valid;
         ex_mem.we    <= id_ex.we;
         ex_mem.load  <= id_ex.load;
         ex_mem.store <= id_ex.store;
      end
   end

   always_ff @(posedge CLK_pi) begin
      ex_mem.result     <= result;
      ex_mem.store_data <= opb;   // captured forwarded, no fixup later
      ex_mem.dest       <= id_ex.dest;
   end

endmodule

// ==== hw/mem_wb_stage.sv ====
`include "cpu_defs.svh"

module mem_wb_stage
   import cpu_pkg::*;
(
   input  logic      CLK_pi,
   input  logic      CPU_RESET_pi,
   ex_mem_if.memory  ex_mem,
   output logic      wb_valid,
   output reg_idx_t  wb_dest,
   output word_t     wb_data
);

   word_t                   dmem [`CPU_DMEM_DEPTH];
   logic [`CPU_DMEM_AW-1:0] addr;       // word address
   word_t                   load_data;

   assign addr      = ex_mem.result[`CPU_DMEM_AW+1:2];  // byte offset ignored
   assign load_data = dmem[addr];                       // async read

   always_ff @(posedge CLK_pi) begin
      if (CPU_RESET_pi) begin
         for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (ex_mem.valid && ex_mem.store) begin
         dmem[addr] <= ex_mem.store_data;
      end
   end

   // MEM/WB register, outputs are the write-back bus
   always_ff @(posedge CLK_pi) begin
      if (CPU_RESET_pi) wb_valid <= 1'b0;
      else              wb_valid <= ex_mem.valid && ex_mem.we;  // we already excludes r0
   end

   always_ff @(posedge CLK_pi) begin
      wb_dest <= ex_mem.dest;
      wb_data <= ex_mem.load ? load_data : ex_mem.result;
   end

endmodule

// ==== hw/pipe_if.sv ====
// ID/EX pipeline register contents
interface id_ex_if
   import cpu_pkg::*;
();
   logic     valid;
   alu_op_e  alu_op;
   logic     use_imm;   // second ALU input is imm
   word_t    imm;       // already sign-extended
   word_t    op1;       // rs value read in decode
   word_t    op2;       // rt value read in decode
   reg_idx_t rs;
   reg_idx_t rt;
   reg_idx_t dest;
   logic     we;        // never set for r0
   logic     load;
   logic     store;

   modport decode (output valid, alu_op, use_imm, imm, op1, op2, rs, rt, dest, we, load, store);
   modport execute (input valid, alu_op, use_imm, imm, op1, op2, rs, rt, dest, we, load, store);
endinterface

// EX/MEM pipeline register contents
interface ex_mem_if
   import cpu_pkg::*;
();
   logic     valid;
   word_t    result;      // ALU result or memory byte address
   word_t    store_data;  // forwarded rt
   reg_idx_t dest;
   logic     we;
   logic     load;
   logic     store;

   modport execute (output valid, result, store_data, dest, we, load, store);
   modport memory (input valid, result, store_data, dest, we, load, store);
endinterface

// ==== hw/reg_file.sv ====
`include "cpu_defs.svh"

module reg_file
   import cpu_pkg::*;
(
   input  logic     CLK_pi,
   input  logic     CPU_RESET_pi,
   input  reg_idx_t rs_idx,
   input  reg_idx_t rt_idx,
   output word_t    rs_data,
   output word_t    rt_data,
   input  logic     wb_valid,
   input  reg_idx_t wb_dest,
   input  word_t    wb_data
);

   word_t regs [2**`CPU_REG_W];

   // wb_valid never comes with dest r0, so regs[0] stays zero after reset
   always_ff @(posedge CLK_pi) begin
      if (CPU_RESET_pi) begin
         for (int i = 0; i < 2**`CPU_REG_W; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_valid) begin
         regs[wb_dest] <= wb_data;
      end
   end

   // write-through, same-cycle write wins over stored value
   assign rs_data = (wb_valid && wb_dest == rs_idx) ? wb_data : regs[rs_idx];
   assign rt_data = (wb_valid && wb_dest == rt_idx) ? wb_data : regs[rt_idx];

endmodule

// ==== project.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/pipe_if.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/cpu_top.sv
tests/cpu_assertions.sv
tests/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module cpu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vcpu_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^TEST PASS$"; then
   exit 0
fi
exit 1

// ==== tests/cpu_assertions.sv ====
module cpu_assertions
   import cpu_pkg::*;
(
   input logic     CLK_pi,
   input logic     CPU_RESET_pi,
   input logic     instr_valid,
   input logic     wb_valid,
   input reg_idx_t wb_dest,
   input logic     ex_load,     // EX/MEM holds a load
   input logic     ex_we,
   input reg_idx_t ex_dest,
   input logic     id_valid,    // ID/EX, the next instruction
   input logic     id_use_imm,
   input logic     id_store,
   input reg_idx_t id_rs,
   input reg_idx_t id_rt
);

   logic rt_read;   // rt is a real source: R-type or store data

   assign rt_read = !id_use_imm || id_store;

   a_reset_quiet: assert property (@(posedge CLK_pi) CPU_RESET_pi |=> !wb_valid)
      else $error("wb_valid high during or right after reset");

   a_no_r0: assert property (@(posedge CLK_pi) disable iff (CPU_RESET_pi)
      wb_valid |-> wb_dest != '0)
      else $error("write-back to r0");

   // four edges from IF/ID to the wb ports
   a_latency: assert property (@(posedge CLK_pi) disable iff (CPU_RESET_pi)
      wb_valid |-> $past(instr_valid, 4))
      else $error("write-back without an instruction four cycles earlier");

   // no interlock, so a load result must skip one instruction
   a_load_use: assert property (@(posedge CLK_pi) disable iff (CPU_RESET_pi)
      (ex_load && ex_we && id_valid) |-> (id_rs != ex_dest && !(rt_read && id_rt == ex_dest)))
      else $error("load result used by the very next instruction");

endmodule

bind cpu_top cpu_assertions i_assertions (
   .CLK_pi       (CLK_pi),
   .CPU_RESET_pi (CPU_RESET_pi),
   .instr_valid  (instr_valid),
   .wb_valid     (wb_valid),
   .wb_dest      (wb_dest),
   .ex_load      (u_ex_mem.load),
   .ex_we        (u_ex_mem.we),
   .ex_dest      (u_ex_mem.dest),
   .id_valid     (u_id_ex.valid),
   .id_use_imm   (u_id_ex.use_imm),
   .id_store     (u_id_ex.store),
   .id_rs        (u_id_ex.rs),
   .id_rt        (u_id_ex.rt)
);

// ==== tests/cpu_tb.sv ====
module cpu_tb
   import cpu_pkg::*;
();

   localparam int WB_TIMEOUT = 40;   // cycles per wait for a write-back

   typedef struct packed {
      int       test;
      word_t    ins;
      int       gap;    // bubbles after the instruction, -1 random
      logic     we;     // write-back expected
      reg_idx_t dest;
      word_t    data;
   } row_t;

   logic     CLK_pi;
   logic     CPU_RESET_pi;
   word_t    instr;
   logic     instr_valid;
   logic     wb_valid;
   reg_idx_t wb_dest;
   word_t    wb_data;

   row_t rows[$];
   int   pending[$];   // row indices of expected writes, in order
   int   checks;
   int   errors;
   int   test_errs[7];

   cpu_top i_dut (
      .CLK_pi       (CLK_pi),
      .CPU_RESET_pi (CPU_RESET_pi),
      .instr        (instr),
      .instr_valid  (instr_valid),
      .wb_valid     (wb_valid),
      .wb_dest      (wb_dest),
      .wb_data      (wb_data)
   );

   initial begin
      CLK_pi = 1'b0;
      forever #2 CLK_pi = ~CLK_pi;
   end

   function automatic word_t enc_r(input logic [5:0] funct, input reg_idx_t rs,
                                   input reg_idx_t rt, input reg_idx_t rd);
      return {6'h00, rs, rt, rd, 5'd0, funct};
   endfunction

   function automatic word_t enc_i(input logic [5:0] op, input reg_idx_t rs,
                                   input reg_idx_t rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function void add_row(input int t, input word_t ins, input int gap, input logic we,
                         input reg_idx_t dest, input word_t data);
      rows.push_back('{t, ins, gap, we, dest, data});
      if (we) pending.push_back(rows.size() - 1);
   endfunction

   task automatic check_valid(input int t, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         $display("** Error: wb_valid = 0x%h, expected 0x%h (test %0d)", got, exp, t);
         errors++;
         test_errs[t]++;
      end
   endtask

   task automatic check_dest(input int t, input reg_idx_t got, input reg_idx_t exp);
      checks++;
      if (got !== exp) begin
         $display("** Error: wb_dest = 0x%h, expected 0x%h (test %0d)", got, exp, t);
         errors++;
         test_errs[t]++;
      end
   endtask

   task automatic check_data(input int t, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         $display("** Error: wb_data = 0x%h, expected 0x%h (test %0d)", got, exp, t);
         errors++;
         test_errs[t]++;
      end
   endtask

   // sampled at negedge, well away from the DUT's edge
   task automatic wait_wb(output logic seen);
      int cycles;
      cycles = 0;
      seen = 1'b0;
      while (!seen && cycles < WB_TIMEOUT) begin
         @(negedge CLK_pi);
         cycles++;
         seen = wb_valid;
      end
   endtask

   function void build_table();
      // 1: values right after reset
      add_row(1, enc_r(F_ADD, 5'd2, 5'd3, 5'd1), 0, 1'b1, 5'd1, 32'h0);
      // 2: independent ops, sources already in the register file
      add_row(2, enc_i(OP_ADDI, 5'd0, 5'd2, 16'h1234), 0, 1'b1, 5'd2, 32'h0000_1234);
      add_row(2, enc_i(OP_ADDI, 5'd0, 5'd3, 16'hFFFB), 0, 1'b1, 5'd3, 32'hFFFF_FFFB);
      add_row(2, enc_i(OP_ADDI, 5'd0, 5'd4, 16'h7F0F), 0, 1'b1, 5'd4, 32'h0000_7F0F);
      add_row(2, enc_i(OP_ADDI, 5'd0, 5'd5, 16'h8000), 3, 1'b1, 5'd5, 32'hFFFF_8000);
      add_row(2, enc_r(F_ADD, 5'd2, 5'd3, 5'd6), 0, 1'b1, 5'd6, 32'h0000_122F);
      add_row(2, enc_r(F_SUB, 5'd2, 5'd4, 5'd7), 0, 1'b1, 5'd7, 32'hFFFF_9325);
      add_row(2, enc_r(F_AND, 5'd3, 5'd4, 5'd8), 0, 1'b1, 5'd8, 32'h0000_7F0B);
      add_row(2, enc_r(F_OR, 5'd2, 5'd5, 5'd9), 0, 1'b1, 5'd9, 32'hFFFF_9234);
      add_row(2, enc_r(F_XOR, 5'd3, 5'd4, 5'd10), 0, 1'b1, 5'd10, 32'hFFFF_80F4);
      add_row(2, enc_i(OP_ADDI, 5'd2, 5'd11, 16'hFFCC), 3, 1'b1, 5'd11, 32'h0000_1200);
      // 3: chain at distance 1, 2, 3, then MEM beats WB on r17
      add_row(3, enc_i(OP_ADDI, 5'd0, 5'd12, 16'h000A), 0, 1'b1, 5'd12, 32'h0A);
      add_row(3, enc_r(F_ADD, 5'd12, 5'd12, 5'd13), 0, 1'b1, 5'd13, 32'h14);
      add_row(3, enc_r(F_SUB, 5'd13, 5'd12, 5'd14), 0, 1'b1, 5'd14, 32'h0A);
      add_row(3, enc_r(F_ADD, 5'd12, 5'd13, 5'd15), 0, 1'b1, 5'd15, 32'h1E);
      add_row(3, enc_r(F_XOR, 5'd14, 5'd15, 5'd16), 0, 1'b1, 5'd16, 32'h14);
      add_row(3, enc_i(OP_ADDI, 5'd0, 5'd17, 16'h0001), 0, 1'b1, 5'd17, 32'h01);
      add_row(3, enc_i(OP_ADDI, 5'd0, 5'd17, 16'h0002), 0, 1'b1, 5'd17, 32'h02);
      add_row(3, enc_r(F_ADD, 5'd17, 5'd0, 5'd18), 3, 1'b1, 5'd18, 32'h02);
      // 4: store then load, forwarded address and store data
      add_row(4, enc_i(OP_ADDI, 5'd0, 5'd20, 16'h0040), 0, 1'b1, 5'd20, 32'h40);
      add_row(4, enc_i(OP_SW, 5'd20, 5'd10, 16'h0008), 0, 1'b0, 5'd0, 32'h0);
      add_row(4, enc_i(OP_LW, 5'd20, 5'd21, 16'h0008), 0, 1'b1, 5'd21, 32'hFFFF_80F4);
      add_row(4, enc_i(OP_ADDI, 5'd0, 5'd22, 16'h0003), 0, 1'b1, 5'd22, 32'h03);
      add_row(4, enc_r(F_ADD, 5'd21, 5'd22, 5'd23), 0, 1'b1, 5'd23, 32'hFFFF_80F7);
      add_row(4, enc_i(OP_ADDI, 5'd0, 5'd24, 16'h0055), 0, 1'b1, 5'd24, 32'h55);
      add_row(4, enc_i(OP_SW, 5'd0, 5'd24, 16'h0104), 0, 1'b0, 5'd0, 32'h0);
      add_row(4, enc_i(OP_LW, 5'd0, 5'd25, 16'h0104), 0, 1'b1, 5'd25, 32'h55);
      add_row(4, enc_i(OP_ADDI, 5'd0, 5'd26, 16'h0007), 0, 1'b1, 5'd26, 32'h07);
      add_row(4, enc_r(F_SUB, 5'd25, 5'd26, 5'd27), 3, 1'b1, 5'd27, 32'h4E);
      // 5: unknown opcode and funct, writes to r0
      add_row(5, enc_i(6'h3F, 5'd2, 5'd30, 16'h0001), 0, 1'b0, 5'd0, 32'h0);
      add_row(5, enc_r(6'h27, 5'd2, 5'd3, 5'd30), 0, 1'b0, 5'd0, 32'h0);
      add_row(5, enc_i(OP_ADDI, 5'd0, 5'd0, 16'h0099), 0, 1'b0, 5'd0, 32'h0);
      add_row(5, enc_r(F_ADD, 5'd2, 5'd3, 5'd0), 0, 1'b0, 5'd0, 32'h0);
      add_row(5, enc_r(F_ADD, 5'd0, 5'd0, 5'd28), 0, 1'b1, 5'd28, 32'h0);
      add_row(5, enc_r(F_OR, 5'd30, 5'd0, 5'd29), 3, 1'b1, 5'd29, 32'h0);
      // 6: same kind of program with random bubbles
      add_row(6, enc_i(OP_ADDI, 5'd0, 5'd1, 16'h0100), -1, 1'b1, 5'd1, 32'h100);
      add_row(6, enc_i(OP_ADDI, 5'd1, 5'd2, 16'h0023), -1, 1'b1, 5'd2, 32'h123);
      add_row(6, enc_r(F_XOR, 5'd1, 5'd2, 5'd3), -1, 1'b1, 5'd3, 32'h023);
      add_row(6, enc_i(OP_SW, 5'd1, 5'd3, 16'h0020), -1, 1'b0, 5'd0, 32'h0);
      add_row(6, enc_i(OP_LW, 5'd1, 5'd4, 16'h0020), -1, 1'b1, 5'd4, 32'h023);
      add_row(6, enc_i(OP_ADDI, 5'd2, 5'd5, 16'hFFFF), -1, 1'b1, 5'd5, 32'h122);
      add_row(6, enc_r(F_SUB, 5'd5, 5'd4, 5'd6), -1, 1'b1, 5'd6, 32'h0FF);
      add_row(6, enc_r(F_OR, 5'd6, 5'd2, 5'd7), 0, 1'b1, 5'd7, 32'h1FF);
   endfunction

   initial begin
      int   gap;
      int   k;
      logic seen;
      void'($urandom(32'h87af));
      checks = 0;
      errors = 0;
      foreach (test_errs[t]) test_errs[t] = 0;
      CPU_RESET_pi = 1'b1;
      instr = '0;
      instr_valid = 1'b0;
      build_table();
      repeat (5) @(posedge CLK_pi);
      #1;
      CPU_RESET_pi = 1'b0;
      repeat (3) begin
         @(negedge CLK_pi);
         check_valid(1, wb_valid, 1'b0);   // quiet until the first write
      end
      fork
         begin   // driver
            foreach (rows[i]) begin
               @(posedge CLK_pi);
               #1;
               instr = rows[i].ins;
               instr_valid = 1'b1;
               gap = (rows[i].gap < 0) ? int'($urandom % 4) : rows[i].gap;
               repeat (gap) begin
                  @(posedge CLK_pi);
                  #1;
                  instr = $urandom;   // junk word under a low strobe
                  instr_valid = 1'b0;
               end
            end
            @(posedge CLK_pi);
            #1;
            instr_valid = 1'b0;
         end
         begin   // monitor
            while (pending.size() > 0) begin
               k = pending.pop_front();
               wait_wb(seen);
               if (!seen) begin
                  $display("test %0d: no write-back to r%0d arrived in time",
                           rows[k].test, rows[k].dest);
                  errors++;
                  test_errs[rows[k].test]++;
                  break;
               end
               check_dest(rows[k].test, wb_dest, rows[k].dest);
               check_data(rows[k].test, wb_data, rows[k].data);
               if (pending.size() == 0 || rows[pending[0]].test != rows[k].test)
                  $display("test %0d done, %0d errors", rows[k].test, test_errs[rows[k].test]);
            end
         end
      join
      repeat (8) begin
         @(negedge CLK_pi);
         check_valid(6, wb_valid, 1'b0);   // nothing left over
      end
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule
